/* design/audio_comp.sv */
// Stereo dynamic range compressor
`timescale 1ns/1ps
`include "emu_cfg.svh"
`default_nettype none

module audio_comp import emu_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	input wire comp_en,
	input wire comp_curve,
	input wire in_valid,
	input wire sample_t in_l,
	input wire sample_t in_r,
	output logic out_valid,
	output sample_t out_l,
	output sample_t out_r
);

	////////////////////////////////////////////////////////////
	// Sample helpers
	////////////////////////////////////////////////////////////
	// Magnitude fits 16 bits unsigned, -32768 gives 0x8000
	function automatic logic [15:0] magnitude(input sample_t s);
		return s[15] ? 16'(-s) : 16'(s);
	endfunction

	// Piecewise curve on the magnitude, clamped to full scale
	function automatic logic [15:0] shape_mag(input logic [15:0] mag, input logic hard);
		int v;
		int knee;
		int gain;
		int div;
		int ofs;
		int r;
		v = int'(mag);
		knee = hard ? `EMU_COMP_X2 : `EMU_COMP_X1;
		gain = hard ? `EMU_COMP_A2 : `EMU_COMP_A1;
		div = hard ? `EMU_COMP_F2 : `EMU_COMP_F1;
		ofs = hard ? `EMU_COMP_B2 : `EMU_COMP_B1;
		// Linear boost below the knee, gentle slope above
		r = (v < knee) ? v * gain : (v - knee) / div + ofs;
		if (r > `EMU_SAMPLE_MAX) r = `EMU_SAMPLE_MAX;
		return r[15:0];
	endfunction

	// Sign back on, 0x8000 negated stays -32768 for bypass
	function automatic sample_t apply_sign(input logic [15:0] mag, input logic neg);
		return neg ? -$signed(mag) : $signed(mag);
	endfunction

	////////////////////////////////////////////////////////////
	// Stage 1, split sign and magnitude
	////////////////////////////////////////////////////////////
	logic s1_valid;
	logic s1_en;
	logic s1_hard;
	logic s1_neg_l;
	logic s1_neg_r;
	logic [15:0] s1_mag_l;
	logic [15:0] s1_mag_r;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			out_valid <= s1_valid;
		end
	end

	// Controls travel with the sample they apply to
	always_ff @(posedge clk_sys) begin
		s1_en <= comp_en;
		s1_hard <= comp_curve;
		s1_neg_l <= in_l[15];
		s1_neg_r <= in_r[15];
		s1_mag_l <= magnitude(in_l);
		s1_mag_r <= magnitude(in_r);
	end

	////////////////////////////////////////////////////////////
	// Stage 2, curve, clamp and sign restore
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		out_l <= apply_sign(s1_en ? shape_mag(s1_mag_l, s1_hard) : s1_mag_l, s1_neg_l);
		out_r <= apply_sign(s1_en ? shape_mag(s1_mag_r, s1_hard) : s1_mag_r, s1_neg_r);
	end

endmodule

`default_nettype wire

/* design/ce_gen.sv */
// System, sound and MPU clock enables
`timescale 1ns/1ps
`include "emu_cfg.svh"
`default_nettype none

module ce_gen import emu_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	input wire ce_mode_t snd_mode,
	output logic sys_ce,
	output logic snd_ce,
	output logic mpu_ce
);

	// Counter widths and terminal counts per rate
	localparam int SYS_W = $clog2(`EMU_SYS_DIV);
	localparam int MPU_W = $clog2(`EMU_MPU_DIV);
	localparam int SND_A_W = $clog2(`EMU_SND_DIV_A);
	localparam int SND_B_W = $clog2(`EMU_SND_DIV_B);
	localparam logic [SYS_W-1:0] SYS_LAST = SYS_W'(`EMU_SYS_DIV - 1);
	localparam logic [MPU_W-1:0] MPU_LAST = MPU_W'(`EMU_MPU_DIV - 1);
	localparam logic [SND_A_W-1:0] SND_A_LAST = SND_A_W'(`EMU_SND_DIV_A - 1);
	localparam logic [SND_B_W-1:0] SND_B_LAST = SND_B_W'(`EMU_SND_DIV_B - 1);

	logic [SYS_W-1:0] sys_cnt;
	logic [MPU_W-1:0] mpu_cnt;
	logic [SND_A_W-1:0] snd_a_cnt;
	logic [SND_B_W-1:0] snd_b_cnt;
	ce_mode_t mode_q;
	logic mode_chg;

	////////////////////////////////////////////////////////////
	// Fixed-rate enables
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sys_cnt <= '0;
			mpu_cnt <= '0;
			sys_ce <= 1'b0;
			mpu_ce <= 1'b0;
		end else begin
			// Wrap at the terminal count, pulse one cycle later
			sys_cnt <= (sys_cnt == SYS_LAST) ? '0 : sys_cnt + 1'b1;
			mpu_cnt <= (mpu_cnt == MPU_LAST) ? '0 : mpu_cnt + 1'b1;
			sys_ce <= (sys_cnt == SYS_LAST);
			mpu_ce <= (mpu_cnt == MPU_LAST);
		end
	end

	////////////////////////////////////////////////////////////
	// Sound enable, one counter per rate
	////////////////////////////////////////////////////////////
	assign mode_chg = (snd_mode != mode_q);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			snd_a_cnt <= '0;
			snd_b_cnt <= '0;
			mode_q <= snd_div5;
			snd_ce <= 1'b0;
		end else begin
			mode_q <= snd_mode;
			if (mode_chg) begin
				// New rate starts a full period from here
				snd_a_cnt <= '0;
				snd_b_cnt <= '0;
				snd_ce <= 1'b0;
			end else begin
				snd_a_cnt <= (snd_a_cnt == SND_A_LAST) ? '0 : snd_a_cnt + 1'b1;
				snd_b_cnt <= (snd_b_cnt == SND_B_LAST) ? '0 : snd_b_cnt + 1'b1;
				snd_ce <= (snd_mode == snd_div10) ? (snd_b_cnt == SND_B_LAST) :
					(snd_a_cnt == SND_A_LAST);
			end
		end
	end

	// Sound pulses never merge, not even across a mode switch
	a_snd_ce_single: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		snd_ce |=> !snd_ce
	);

endmodule

`default_nettype wire

/* design/emu_cfg.svh */
// Emulator configuration constants
`ifndef EMU_CFG_SVH
`define EMU_CFG_SVH

////////////////////////////////////////////////////////////
// APB register map, byte addresses
////////////////////////////////////////////////////////////
`define EMU_REG_CTRL   4'h0
`define EMU_REG_STATUS 4'h4
`define EMU_REG_COUNT  4'h8

////////////////////////////////////////////////////////////
// Clock-enable periods in clk_sys cycles
////////////////////////////////////////////////////////////
`define EMU_SYS_DIV   4
`define EMU_MPU_DIV   2
`define EMU_SND_DIV_A 5
`define EMU_SND_DIV_B 10

////////////////////////////////////////////////////////////
// Compressor curves: knee, low gain, high divisor, offset
////////////////////////////////////////////////////////////
// Soft curve, 2x below the knee
`define EMU_COMP_X1 14044
`define EMU_COMP_A1 2
`define EMU_COMP_F1 4
`define EMU_COMP_B1 28088
// Hard curve, 4x below the knee
`define EMU_COMP_X2 7400
`define EMU_COMP_A2 4
`define EMU_COMP_F2 8
`define EMU_COMP_B2 29600
// Largest positive magnitude after shaping
`define EMU_SAMPLE_MAX 32767

`endif

/* design/emu_pkg.sv */
// Emulator shared types
`default_nettype none

package emu_pkg;

	////////////////////////////////////////////////////////////
	// Bus and data widths
	////////////////////////////////////////////////////////////
	// APB byte address and data word
	typedef logic [3:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;
	// One signed audio sample per channel
	typedef logic signed [15:0] sample_t;
	// Loader address, payload byte and accepted-byte count
	typedef logic [19:0] ldr_addr_t;
	typedef logic [7:0]  ldr_byte_t;
	typedef logic [19:0] ldr_count_t;

	////////////////////////////////////////////////////////////
	// State encodings
	////////////////////////////////////////////////////////////
	// Sound enable rate, one pulse in 5 or in 10 cycles
	typedef enum logic {snd_div5 = 1'b0, snd_div10 = 1'b1} ce_mode_t;
	// Download progress as seen by the loader
	typedef enum logic [1:0] {idle = 2'd0, loading = 2'd1, done = 2'd2} ldr_state_t;

endpackage

`default_nettype wire

/* design/emu_regs.sv */
// APB control and status registers
`timescale 1ns/1ps
`include "emu_cfg.svh"
`default_nettype none

module emu_regs import emu_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	// APB slave
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire apb_addr_t paddr,
	input wire apb_data_t pwdata,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	// Status from the loader
	input wire ldr_done,
	input wire core_rst_n,
	input wire ldr_count_t ldr_count,
	// Control to the other blocks
	output logic soft_reset,
	output ce_mode_t snd_mode,
	output logic comp_curve,
	output logic comp_en
);

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////
	logic [3:0] ctrl_q;
	logic access;
	logic addr_hit;
	logic wr_ctrl;

	// Access phase of any transfer
	assign access = psel && penable;

	// Only three word addresses exist in the map
	assign addr_hit = (paddr == `EMU_REG_CTRL) ||
		(paddr == `EMU_REG_STATUS) ||
		(paddr == `EMU_REG_COUNT);

	// STATUS and COUNT silently ignore writes
	assign wr_ctrl = access && pwrite && (paddr == `EMU_REG_CTRL);

	////////////////////////////////////////////////////////////
	// CTRL register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ctrl_q <= '0;
		end else if (wr_ctrl) begin
			// Upper bits of the word are not stored
			ctrl_q <= pwdata[3:0];
		end
	end

	// Field split of CTRL
	assign soft_reset = ctrl_q[0];
	assign snd_mode = ce_mode_t'(ctrl_q[1]);
	// 1 picks the hard curve
	assign comp_curve = ctrl_q[2];
	assign comp_en = ctrl_q[3];

	////////////////////////////////////////////////////////////
	// Read mux and response
	////////////////////////////////////////////////////////////
	always_comb begin
		prdata = '0;
		case (paddr)
			`EMU_REG_CTRL: begin
				prdata[3:0] = ctrl_q;
			end
			`EMU_REG_STATUS: begin
				// bit 0 download finished, bit 1 core out of reset
				prdata[0] = ldr_done;
				prdata[1] = core_rst_n;
			end
			`EMU_REG_COUNT: begin
				prdata[19:0] = ldr_count;
			end
			default: begin
				prdata = '0;
			end
		endcase
	end

	// No wait states, every access completes at once
	assign pready = 1'b1;

	// Error only during the access phase of an unmapped address
	assign pslverr = access && !addr_hit;

	////////////////////////////////////////////////////////////
	// Bus protocol check
	////////////////////////////////////////////////////////////
	// The master may only raise penable on a selected transfer
	a_penable_needs_psel: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		penable |-> psel
	);

endmodule

`default_nettype wire

/* design/emu_top.sv */
// Emulator top level
`timescale 1ns/1ps
`default_nettype none

module emu_top import emu_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	// APB slave
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire apb_addr_t paddr,
	input wire apb_data_t pwdata,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	// Host download port and core write port
	input wire ioctl_download,
	input wire ioctl_wr,
	input wire ldr_addr_t ioctl_addr,
	input wire ldr_byte_t ioctl_dout,
	output logic ioctl_wait,
	input wire ldr_ack,
	output logic ldr_wr,
	output ldr_addr_t ldr_addr,
	output ldr_byte_t ldr_wdat,
	output logic ldr_done,
	output ldr_count_t ldr_count,
	output logic core_rst_n,
	// Clock enables
	output logic sys_ce,
	output logic snd_ce,
	output logic mpu_ce,
	// Audio stream
	input wire in_valid,
	input wire sample_t in_l,
	input wire sample_t in_r,
	output logic out_valid,
	output sample_t out_l,
	output sample_t out_r
);

	// CTRL fields fanned out to the datapath blocks
	logic soft_reset;
	ce_mode_t snd_mode;
	logic comp_curve;
	logic comp_en;

	emu_regs u_regs (
		.clk_sys(clk_sys), .rst_n(rst_n), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .ldr_done(ldr_done),
		.core_rst_n(core_rst_n), .ldr_count(ldr_count), .soft_reset(soft_reset),
		.snd_mode(snd_mode), .comp_curve(comp_curve), .comp_en(comp_en)
	);

	ce_gen u_ce_gen (
		.clk_sys(clk_sys), .rst_n(rst_n), .snd_mode(snd_mode),
		.sys_ce(sys_ce), .snd_ce(snd_ce), .mpu_ce(mpu_ce)
	);

	// Loader status also feeds back into STATUS and COUNT
	rom_loader u_loader (
		.clk_sys(clk_sys), .rst_n(rst_n), .soft_reset(soft_reset),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ldr_ack(ldr_ack), .ioctl_wait(ioctl_wait),
		.ldr_wr(ldr_wr), .ldr_addr(ldr_addr), .ldr_wdat(ldr_wdat),
		.ldr_done(ldr_done), .ldr_count(ldr_count), .core_rst_n(core_rst_n)
	);

	audio_comp u_comp (
		.clk_sys(clk_sys), .rst_n(rst_n), .comp_en(comp_en), .comp_curve(comp_curve),
		.in_valid(in_valid), .in_l(in_l), .in_r(in_r),
		.out_valid(out_valid), .out_l(out_l), .out_r(out_r)
	);

endmodule

`default_nettype wire

/* design/rom_loader.sv */
// ROM download write handshake
`timescale 1ns/1ps
`default_nettype none

module rom_loader import emu_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	input wire soft_reset,
	// Host download port
	input wire ioctl_download,
	input wire ioctl_wr,
	input wire ldr_addr_t ioctl_addr,
	input wire ldr_byte_t ioctl_dout,
	output logic ioctl_wait,
	// Core write port
	input wire ldr_ack,
	output logic ldr_wr,
	output ldr_addr_t ldr_addr,
	output ldr_byte_t ldr_wdat,
	// Status
	output logic ldr_done,
	output ldr_count_t ldr_count,
	output logic core_rst_n
);

	ldr_state_t state;
	logic accept;

	////////////////////////////////////////////////////////////
	// Download tracking
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			case (state)
				// First sample of ioctl_download high starts the load
				idle: if (ioctl_download) state <= loading;
				// Falling download ends it for good
				loading: if (!ioctl_download) state <= done;
				default: state <= done;
			endcase
		end
	end

	assign ldr_done = (state == done);

	// Core runs once a download has begun, unless held by software
	assign core_rst_n = (state != idle) && !soft_reset;

	////////////////////////////////////////////////////////////
	// Write handshake
	////////////////////////////////////////////////////////////
	// New byte only between writes and before the load is finished
	assign accept = ioctl_wr && ioctl_download && !ldr_wr && (state != done);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ldr_wr <= 1'b0;
			ldr_count <= '0;
		end else if (ldr_wr && ldr_ack) begin
			// Core took the byte
			ldr_wr <= 1'b0;
			ldr_count <= ldr_count + 1'b1;
		end else if (accept) begin
			ldr_wr <= 1'b1;
		end
	end

	// Address and data held for the whole write
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			ldr_addr <= ioctl_addr;
			ldr_wdat <= ioctl_dout;
		end
	end

	// Host stalls for exactly as long as the core write is pending
	assign ioctl_wait = ldr_wr;

	////////////////////////////////////////////////////////////
	// Handshake checks
	////////////////////////////////////////////////////////////
	// Host honours the stall
	a_no_wr_in_wait: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wait |-> !ioctl_wr
	);

	// Core sees a steady write until it acknowledges
	a_wr_payload_stable: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		ldr_wr && !ldr_ack |=> $stable(ldr_addr) && $stable(ldr_wdat)
	);

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/emu_pkg.sv
design/emu_regs.sv
design/ce_gen.sv
design/rom_loader.sv
design/audio_comp.sv
design/emu_top.sv
verification/tb_emu.sv

/* run.sh */
#!/bin/sh
# Build and run the emulator testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_emu -f filelist.f -o tb_emu &&
./obj_dir/tb_emu || {
	echo "simulation returned a failing status"
	exit 1
}

/* verification/emu_patterns.txt */
# comp_en comp_curve in_l in_r exp_l exp_r, samples in signed decimal
# comp_curve 0 is the soft curve, 1 the hard curve, comp_en 0 is bypass
1 0 1000 -1000 2000 -2000
1 0 14043 -14043 28086 -28086
1 0 14044 -14044 28088 -28088
1 0 14047 -14048 28088 -28089
1 0 20000 -20000 29577 -29577
1 0 32767 -32768 32767 -32767
1 0 0 7 0 14
1 0 7400 -3 14800 -6
1 0 10000 -10000 20000 -20000
1 0 -32768 32767 -32767 32767
1 1 1000 -1000 4000 -4000
1 1 7399 -7399 29596 -29596
1 1 7400 -7400 29600 -29600
1 1 8191 -8192 29698 -29699
1 1 16000 -16000 30675 -30675
1 1 32767 -32768 32767 -32767
1 1 14044 -5 30430 -20
1 1 -32768 32767 -32767 32767
1 1 100 -1 400 -4
0 0 1234 -4321 1234 -4321
0 0 32767 -32768 32767 -32768
0 1 20000 -7400 20000 -7400
0 1 -32768 0 -32768 0

/* verification/tb_emu.sv */
// Emulator top-level testbench
`timescale 1ns/1ps
`include "emu_cfg.svh"
`default_nettype none

module tb_emu import emu_pkg::*; ();

	logic clk_sys;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic ioctl_download;
	logic ioctl_wr;
	ldr_addr_t ioctl_addr;
	ldr_byte_t ioctl_dout;
	logic ioctl_wait;
	logic ldr_ack;
	logic ldr_wr;
	ldr_addr_t ldr_addr;
	ldr_byte_t ldr_wdat;
	logic ldr_done;
	ldr_count_t ldr_count;
	logic core_rst_n;
	logic sys_ce;
	logic snd_ce;
	logic mpu_ce;
	logic in_valid;
	sample_t in_l;
	sample_t in_r;
	logic out_valid;
	sample_t out_l;
	sample_t out_r;

	emu_top u_dut (.*);

	// 8 ns system clock
	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting and compares
	////////////////////////////////////////////////////////////
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %0b expected %0b", $time, name, got, exp));
	endtask

	task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_count(input string name, input ldr_count_t got, input ldr_count_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	// Cycle distances between enable pulses and pipeline latency
	task automatic check_gap(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// APB master, called on a falling edge
	////////////////////////////////////////////////////////////
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk_sys);
		penable = 1'b1;
		// Let the combinational response settle
		#1;
		// No wait states on this slave
		check_bit("pready", pready, 1'b1);
		// Only mapped addresses are written
		check_bit("pslverr", pslverr, 1'b0);
		@(negedge clk_sys);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk_sys);
		penable = 1'b1;
		#1;
		check_bit("pready", pready, 1'b1);
		// Access phase, read data and error are settled here
		data = prdata;
		err = pslverr;
		@(negedge clk_sys);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Clock enables, loader and audio helpers
	////////////////////////////////////////////////////////////
	// Pulse spacing of all three enables over 40 cycles
	task automatic check_ce_rates(input int snd_period);
		int last_sys;
		int last_mpu;
		int last_snd;
		int n_sys;
		int n_mpu;
		int n_snd;
		last_sys = -1;
		last_mpu = -1;
		last_snd = -1;
		n_sys = 0;
		n_mpu = 0;
		n_snd = 0;
		for (int cyc = 0; cyc < 40; cyc++) begin
			@(negedge clk_sys);
			if (sys_ce) begin
				if (last_sys >= 0) check_gap("sys_ce spacing", cyc - last_sys, `EMU_SYS_DIV);
				last_sys = cyc;
				n_sys++;
			end
			if (mpu_ce) begin
				if (last_mpu >= 0) check_gap("mpu_ce spacing", cyc - last_mpu, `EMU_MPU_DIV);
				last_mpu = cyc;
				n_mpu++;
			end
			if (snd_ce) begin
				if (last_snd >= 0) check_gap("snd_ce spacing", cyc - last_snd, snd_period);
				last_snd = cyc;
				n_snd++;
			end
		end
		if (n_sys < 3 || n_mpu < 3 || n_snd < 3)
			abort_run("a clock enable stayed low for most of 40 cycles");
	endtask

	// One host byte, the core acknowledges after delay cycles
	task automatic load_byte(input ldr_addr_t addr, input ldr_byte_t data, input int delay);
		ioctl_wr = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		// Request and stall are up one cycle after the strobe
		for (int i = 0; i <= delay; i++) begin
			check_bit("ldr_wr", ldr_wr, 1'b1);
			check_bit("ioctl_wait", ioctl_wait, 1'b1);
			check_data("ldr_addr", apb_data_t'(ldr_addr), apb_data_t'(addr));
			check_data("ldr_wdat", apb_data_t'(ldr_wdat), apb_data_t'(data));
			if (i == delay) ldr_ack = 1'b1;
			@(negedge clk_sys);
		end
		ldr_ack = 1'b0;
		// Both drop on the acknowledging edge
		check_bit("ldr_wr", ldr_wr, 1'b0);
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
	endtask

	// One stereo sample through the compressor
	task automatic run_sample(input sample_t l, input sample_t r, input sample_t exp_l,
		input sample_t exp_r);
		int lat;
		in_valid = 1'b1;
		in_l = l;
		in_r = r;
		@(negedge clk_sys);
		in_valid = 1'b0;
		lat = 1;
		while (!out_valid) begin
			@(negedge clk_sys);
			lat++;
			if (lat > 8) abort_run("out_valid never followed in_valid");
		end
		check_gap("out_valid latency", lat, 2);
		check_sample("out_l", out_l, exp_l);
		check_sample("out_r", out_r, exp_r);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		apb_data_t rdata;
		apb_data_t ctrl;
		apb_data_t new_ctrl;
		logic err;
		string line;
		int fd;
		int rc;
		int n;
		int en;
		int curve;
		int il;
		int ir;
		int el;
		int er;
		int lines_run;
		void'($urandom(32'h10f9));
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ldr_ack = 1'b0;
		in_valid = 1'b0;
		in_l = '0;
		in_r = '0;
		repeat (10) @(negedge clk_sys);
		rst_n = 1'b1;
		// Everything starts quiet
		check_bit("ldr_wr", ldr_wr, 1'b0);
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		check_bit("ldr_done", ldr_done, 1'b0);
		check_bit("core_rst_n", core_rst_n, 1'b0);
		check_bit("sys_ce", sys_ce, 1'b0);
		check_bit("snd_ce", snd_ce, 1'b0);
		check_bit("mpu_ce", mpu_ce, 1'b0);
		check_bit("out_valid", out_valid, 1'b0);
		check_bit("pslverr", pslverr, 1'b0);

		// Register readback, unmapped read and ignored STATUS and COUNT writes
		apb_write(`EMU_REG_CTRL, 32'h0000_000C);
		apb_read(`EMU_REG_CTRL, rdata, err);
		check_data("prdata", rdata, 32'h0000_000C);
		check_bit("pslverr", err, 1'b0);
		apb_read(4'hC, rdata, err);
		check_bit("pslverr", err, 1'b1);
		apb_write(`EMU_REG_STATUS, 32'hFFFF_FFFF);
		apb_write(`EMU_REG_COUNT, 32'hFFFF_FFFF);
		apb_read(`EMU_REG_STATUS, rdata, err);
		check_data("prdata", rdata, 32'h0);
		apb_read(`EMU_REG_COUNT, rdata, err);
		check_data("prdata", rdata, 32'h0);
		// CTRL keeps its value
		apb_read(`EMU_REG_CTRL, rdata, err);
		check_data("prdata", rdata, 32'h0000_000C);
		apb_write(`EMU_REG_CTRL, 32'h0);

		// Enable rates in both sound modes
		check_ce_rates(`EMU_SND_DIV_A);
		apb_write(`EMU_REG_CTRL, 32'h2);
		check_ce_rates(`EMU_SND_DIV_B);
		apb_write(`EMU_REG_CTRL, 32'h0);

		// Download of 8 bytes with random core stalls
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		check_bit("core_rst_n", core_rst_n, 1'b1);
		for (int i = 0; i < 8; i++) begin
			load_byte(20'h3_0000 + 20'(i * 3), 8'(8'hA5 ^ (i * 17)), int'($urandom % 6));
			check_count("ldr_count", ldr_count, ldr_count_t'(i + 1));
		end
		apb_read(`EMU_REG_COUNT, rdata, err);
		check_data("prdata", rdata, 32'd8);

		// End of download, late strobe and software core reset
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check_bit("ldr_done", ldr_done, 1'b1);
		apb_read(`EMU_REG_STATUS, rdata, err);
		check_data("prdata", rdata, 32'h3);
		// Strobe inside a second download window is still ignored
		ioctl_download = 1'b1;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		repeat (3) begin
			check_bit("ldr_wr", ldr_wr, 1'b0);
			@(negedge clk_sys);
		end
		ioctl_download = 1'b0;
		check_bit("ldr_done", ldr_done, 1'b1);
		check_count("ldr_count", ldr_count, 20'd8);
		apb_write(`EMU_REG_CTRL, 32'h1);
		check_bit("core_rst_n", core_rst_n, 1'b0);
		apb_read(`EMU_REG_STATUS, rdata, err);
		check_data("prdata", rdata, 32'h1);
		apb_write(`EMU_REG_CTRL, 32'h0);
		check_bit("core_rst_n", core_rst_n, 1'b1);

		// Compressor patterns, CTRL rewritten when the mode changes
		fd = $fopen("verification/emu_patterns.txt", "r");
		if (fd == 0) abort_run("cannot open verification/emu_patterns.txt");
		ctrl = '0;
		lines_run = 0;
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			if (rc > 0) begin
				n = $sscanf(line, "%d %d %d %d %d %d", en, curve, il, ir, el, er);
				if (n == 6) begin
					new_ctrl = {28'd0, en[0], curve[0], 2'b00};
					if (new_ctrl != ctrl) begin
						apb_write(`EMU_REG_CTRL, new_ctrl);
						ctrl = new_ctrl;
					end
					run_sample(sample_t'(il), sample_t'(ir), sample_t'(el), sample_t'(er));
					lines_run++;
				end else if (n > 0) begin
					abort_run("malformed line in the pattern file");
				end
			end
		end
		$fclose(fd);
		if (lines_run < 20) abort_run("too few pattern lines were applied");

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
